// File: Makefile
TOP = tb_fp_pipeline
LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module fp_pipeline

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

// File: fp_control_pkg.sv
// Control types for the vector FP pipeline
// Operation encoding, hardware thread index, pipeline selector

package fp_control_pkg;

	// Hardware threads sharing the pipeline
	localparam int NUM_THREADS = 4;

	typedef logic [$clog2(NUM_THREADS)-1:0] thread_idx_t;

	// Operations handled by this pipeline
	typedef enum logic [2:0]
	{
		OP_FADD,
		OP_FSUB,
		OP_FMUL,
		OP_FTOI,
		OP_MUL_LO,
		OP_MULH_S
	} fp_op_t;

	// Source of a rollback request at writeback
	typedef enum logic [1:0]
	{
		PIPE_MEM,
		PIPE_INT,
		PIPE_FP
	} pipeline_sel_t;

endpackage

// File: fp_execute_stage1.sv
// FP execute stage 1
// Operand unpack with denormal flush, magnitude ordering,
// alignment and float-to-int shifts, infinity and NaN detection
`timescale 1ns/1ps
`include "fp_macros.svh"

module fp_execute_stage1(
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input fp_control_pkg::fp_op_t issue_op,
	input fp_control_pkg::thread_idx_t issue_thread_idx,
	input fp_format_pkg::lane_mask_t issue_mask,
	input fp_format_pkg::scalar_t [`VECTOR_LANES-1:0] operand_a,
	input fp_format_pkg::scalar_t [`VECTOR_LANES-1:0] operand_b,
	fx1_if.src fx1);

	import fp_format_pkg::*;
	import fp_control_pkg::*;

	// Exponent at which |x| reaches 2^31
	localparam exponent_t FTOI_MAX_EXP = exponent_t'(EXP_BIAS + 31);

	logic is_fsub;
	logic is_fmul;
	logic is_ftoi;

	assign is_fsub = issue_op == OP_FSUB;
	assign is_fmul = issue_op == OP_FMUL;
	assign is_ftoi = issue_op == OP_FTOI;

	for (genvar lane = 0; lane < `VECTOR_LANES; lane++)
	begin : lane_gen
		logic sign_a;
		logic sign_b;
		exponent_t exp_a;
		exponent_t exp_b;
		logic [FRAC_WIDTH-1:0] frac_a;
		logic [FRAC_WIDTH-1:0] frac_b;
		logic [`SIG_WIDTH-1:0] sig_a;
		logic [`SIG_WIDTH-1:0] sig_b;
		logic inf_a;
		logic inf_b;
		logic nan_a;
		logic nan_b;
		logic swap;
		exponent_t exp_diff;
		logic lane_inf;
		logic lane_nan;
		logic [5:0] ftoi_shift;

		// Field split, subtract folds into the sign of b
		assign sign_a = operand_a[lane][31];
		assign sign_b = operand_b[lane][31] ^ is_fsub;
		assign exp_a = operand_a[lane][FRAC_WIDTH +: EXP_WIDTH];
		assign exp_b = operand_b[lane][FRAC_WIDTH +: EXP_WIDTH];
		assign frac_a = operand_a[lane][FRAC_WIDTH-1:0];
		assign frac_b = operand_b[lane][FRAC_WIDTH-1:0];

		// Zero exponent flushes the whole significand
		assign sig_a = exp_a == '0 ? '0 : {1'b1, frac_a};
		assign sig_b = exp_b == '0 ? '0 : {1'b1, frac_b};
		assign inf_a = exp_a == EXP_MAX && frac_a == '0;
		assign inf_b = exp_b == EXP_MAX && frac_b == '0;
		assign nan_a = exp_a == EXP_MAX && frac_a != '0;
		assign nan_b = exp_b == EXP_MAX && frac_b != '0;

		// Larger magnitude goes to the le side; conversion always uses a
		assign swap = !is_ftoi && operand_b[lane][30:0] > operand_a[lane][30:0];
		assign exp_diff = swap ? exp_b - exp_a : exp_a - exp_b;

		// Right shift of {sig, 8'b0} that drops the fraction
		assign ftoi_shift = exp_a < exponent_t'(EXP_BIAS) ? 6'd32
			: exp_a >= FTOI_MAX_EXP ? 6'd0 : 6'(FTOI_MAX_EXP - exp_a);

		always_comb
		begin
			lane_nan = 1'b0;
			lane_inf = 1'b0;
			case (issue_op)
				OP_FADD, OP_FSUB:
				begin
					// inf - inf has no defined value
					lane_nan = nan_a || nan_b || (inf_a && inf_b && (sign_a ^ sign_b));
					lane_inf = inf_a || inf_b;
				end
				OP_FMUL:
				begin
					lane_nan = nan_a || nan_b || (inf_a && sig_b == '0) || (inf_b && sig_a == '0);
					lane_inf = inf_a || inf_b;
				end
				OP_FTOI:
				begin
					// Out of range saturates in stage 3
					lane_nan = nan_a;
					lane_inf = exp_a >= FTOI_MAX_EXP;
				end
				default:
				begin
					lane_nan = 1'b0;
					lane_inf = 1'b0;
				end
			endcase
		end

		always_ff @(posedge clk)
		begin
			fx1.result_is_inf[lane] <= lane_inf;
			fx1.result_is_nan[lane] <= lane_nan;
			fx1.ftoi_shift[lane] <= ftoi_shift;
			fx1.significand_le[lane] <= swap ? sig_b : sig_a;
			fx1.significand_se[lane] <= swap ? sig_a : sig_b;
			// Anything past 27 lands entirely in sticky
			fx1.se_align_shift[lane] <= exp_diff > 8'd27 ? 5'd27 : exp_diff[4:0];
			fx1.logical_subtract[lane] <= sign_a ^ sign_b;
			fx1.add_exponent[lane] <= swap ? exp_b : exp_a;
			fx1.add_result_sign[lane] <= swap ? sign_b : sign_a;
			fx1.mul_exponent[lane] <= $signed({2'b00, exp_a}) + $signed({2'b00, exp_b})
				- 10'(EXP_BIAS);
			fx1.mul_sign[lane] <= operand_a[lane][31] ^ operand_b[lane][31];
			// Integer ops pass raw operands
			fx1.multiplicand[lane] <= is_fmul ? 32'(sig_a) : operand_a[lane];
			fx1.multiplier[lane] <= is_fmul ? 32'(sig_b) : operand_b[lane];
		end

		// Aligned se never outweighs le
		assert property (@(posedge clk) disable iff (reset)
			fx1.valid && (fx1.op == OP_FADD || fx1.op == OP_FSUB)
			|-> fx1.significand_le[lane]
			>= fx1.significand_se[lane] >> fx1.se_align_shift[lane]);
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			fx1.valid <= 1'b0;
			fx1.op <= OP_FADD;
			fx1.thread_idx <= '0;
			fx1.mask <= '0;
		end
		else
		begin
			fx1.valid <= issue_valid;
			fx1.op <= issue_op;
			fx1.thread_idx <= issue_thread_idx;
			fx1.mask <= issue_mask;
		end
	end
endmodule

// File: fp_execute_stage2.sv
// FP execute stage 2
// Significand alignment with guard, round and sticky,
// full 64-bit product, rollback squash of memory-pipe rollbacks
`timescale 1ns/1ps
`include "fp_macros.svh"

module fp_execute_stage2(
	input logic clk,
	input logic reset,
	input logic rollback_en,
	input fp_control_pkg::thread_idx_t rollback_thread_idx,
	input fp_control_pkg::pipeline_sel_t rollback_pipeline,
	fx1_if.dst fx1,
	fx2_if.src fx2);

	import fp_control_pkg::*;

	logic is_mulh_s;
	logic squash;

	assign is_mulh_s = fx1.op == OP_MULH_S;

	// Only memory-pipe rollbacks of this thread cancel here
	assign squash = rollback_en && rollback_thread_idx == fx1.thread_idx
		&& rollback_pipeline == PIPE_MEM;

	for (genvar lane = 0; lane < `VECTOR_LANES; lane++)
	begin : lane_gen
		logic [`SIG_WIDTH-1:0] aligned_se;
		logic guard;
		logic round;
		logic [24:0] sticky_bits;
		logic [63:0] ext_multiplicand;
		logic [63:0] ext_multiplier;

		// Shift out into 27 extra bits below the significand
		assign {aligned_se, guard, round, sticky_bits} = {fx1.significand_se[lane], 27'd0}
			>> fx1.se_align_shift[lane];

		// Sign extend only for the signed high multiply
		assign ext_multiplicand = {{32{fx1.multiplicand[lane][31] && is_mulh_s}},
			fx1.multiplicand[lane]};
		assign ext_multiplier = {{32{fx1.multiplier[lane][31] && is_mulh_s}},
			fx1.multiplier[lane]};

		always_ff @(posedge clk)
		begin
			fx2.result_is_inf[lane] <= fx1.result_is_inf[lane];
			fx2.result_is_nan[lane] <= fx1.result_is_nan[lane];
			fx2.ftoi_shift[lane] <= fx1.ftoi_shift[lane];
			fx2.significand_le[lane] <= fx1.significand_le[lane];
			fx2.significand_se[lane] <= aligned_se;
			fx2.guard[lane] <= guard;
			fx2.round[lane] <= round;
			fx2.sticky[lane] <= |sticky_bits;
			fx2.add_exponent[lane] <= fx1.add_exponent[lane];
			fx2.add_result_sign[lane] <= fx1.add_result_sign[lane];
			fx2.logical_subtract[lane] <= fx1.logical_subtract[lane];
			// Low 64 bits match the signed product after extension
			fx2.significand_product[lane] <= ext_multiplicand * ext_multiplier;
			fx2.mul_exponent[lane] <= fx1.mul_exponent[lane];
			fx2.mul_sign[lane] <= fx1.mul_sign[lane];
		end

		// Float multiply operands are bare significands, product fits 48 bits
		assert property (@(posedge clk) disable iff (reset)
			fx1.valid && fx1.op == OP_FMUL
			|-> fx1.multiplicand[lane][31:`SIG_WIDTH] == '0
			&& fx1.multiplier[lane][31:`SIG_WIDTH] == '0);
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			fx2.valid <= 1'b0;
			fx2.op <= OP_FADD;
			fx2.thread_idx <= '0;
			fx2.mask <= '0;
		end
		else
		begin
			fx2.valid <= fx1.valid && !squash;
			fx2.op <= fx1.op;
			fx2.thread_idx <= fx1.thread_idx;
			fx2.mask <= fx1.mask;
		end
	end
endmodule

// File: fp_execute_stage3.sv
// FP execute stage 3
// Significand add, normalize, round to nearest even, pack,
// float-to-int conversion and per-op result select
`timescale 1ns/1ps
`include "fp_macros.svh"

module fp_execute_stage3(
	input logic clk,
	input logic reset,
	fx2_if.dst fx2,
	output logic result_valid,
	output fp_control_pkg::thread_idx_t result_thread_idx,
	output fp_format_pkg::lane_mask_t result_mask,
	output fp_format_pkg::scalar_t [`VECTOR_LANES-1:0] result_value);

	import fp_format_pkg::*;
	import fp_control_pkg::*;

	// Zeros above the leading one; 27 when all clear
	function automatic logic [4:0] leading_zeros(input logic [26:0] value);
		logic [4:0] count;
		count = 5'd27;
		for (int i = 0; i < 27; i++)
			if (value[i])
				count = 5'(26 - i);
		return count;
	endfunction

	// Nearest-even round, then flush or saturate on exponent range
	function automatic scalar_t round_pack(input logic sign, input logic signed [9:0] exponent,
		input logic [23:0] significand, input logic guard, input logic sticky);
		logic [24:0] rounded;
		logic signed [9:0] exp_adj;
		rounded = {1'b0, significand} + 25'(guard && (sticky || significand[0]));
		// Carry out of rounding bumps the exponent, fraction already zero
		exp_adj = exponent + $signed({9'd0, rounded[24]});
		if (exp_adj <= 0)
			return {sign, 31'd0};
		if (exp_adj >= 10'sd255)
			return {sign, EXP_MAX, 23'd0};
		return {sign, exp_adj[7:0], rounded[22:0]};
	endfunction

	for (genvar lane = 0; lane < `VECTOR_LANES; lane++)
	begin : lane_gen
		logic [63:0] product;
		logic [26:0] le_ext;
		logic [26:0] se_ext;
		logic [27:0] sum;
		logic [4:0] lz;
		logic [26:0] norm;
		logic signed [9:0] add_exp;
		logic [47:0] mnorm;
		logic signed [9:0] mul_exp;
		logic [31:0] ftoi_mag;
		scalar_t add_result;
		scalar_t mul_result;
		scalar_t lane_result;

		assign product = fx2.significand_product[lane];

		// Add path, three low bits hold guard, round, sticky
		assign le_ext = {fx2.significand_le[lane], 3'b000};
		assign se_ext = {fx2.significand_se[lane], fx2.guard[lane], fx2.round[lane],
			fx2.sticky[lane]};
		assign sum = fx2.logical_subtract[lane] ? {1'b0, le_ext} - {1'b0, se_ext}
			: {1'b0, le_ext} + {1'b0, se_ext};
		assign lz = leading_zeros(sum[26:0]);
		// Carry shifts right keeping sticky, else shift the leading one up
		assign norm = sum[27] ? {sum[27:2], sum[1] | sum[0]} : sum[26:0] << lz;
		assign add_exp = $signed({2'b00, fx2.add_exponent[lane]}) + $signed({9'd0, sum[27]})
			- $signed({5'd0, lz});
		// Exact cancellation gives +0
		assign add_result = sum == '0 ? '0 : round_pack(fx2.add_result_sign[lane], add_exp,
			norm[26:3], norm[2], |norm[1:0]);

		// 24x24 product sits in bits 47:0, leading one at 47 or 46
		assign mnorm = product[47] ? product[47:0] : {product[46:0], 1'b0};
		assign mul_exp = $signed(fx2.mul_exponent[lane]) + $signed({9'd0, product[47]});
		assign mul_result = product[47:46] == 2'b00 ? {fx2.mul_sign[lane], 31'd0}
			: round_pack(fx2.mul_sign[lane], mul_exp, mnorm[47:24], mnorm[23], |mnorm[22:0]);

		// Truncation toward zero
		assign ftoi_mag = {fx2.significand_le[lane], 8'd0} >> fx2.ftoi_shift[lane];

		always_comb
		begin
			case (fx2.op)
				OP_FADD, OP_FSUB:
					if (fx2.result_is_nan[lane])
						lane_result = QUIET_NAN;
					else if (fx2.result_is_inf[lane])
						lane_result = {fx2.add_result_sign[lane], EXP_MAX, 23'd0};
					else
						lane_result = add_result;
				OP_FMUL:
					if (fx2.result_is_nan[lane])
						lane_result = QUIET_NAN;
					else if (fx2.result_is_inf[lane])
						lane_result = {fx2.mul_sign[lane], EXP_MAX, 23'd0};
					else
						lane_result = mul_result;
				OP_FTOI:
					if (fx2.result_is_nan[lane])
						lane_result = INT_MAX;
					else if (fx2.result_is_inf[lane])
						lane_result = fx2.add_result_sign[lane] ? INT_MIN : INT_MAX;
					else
						lane_result = fx2.add_result_sign[lane] ? -ftoi_mag : ftoi_mag;
				OP_MUL_LO:
					lane_result = product[31:0];
				OP_MULH_S:
					lane_result = product[63:32];
				default:
					lane_result = '0;
			endcase
		end

		always_ff @(posedge clk)
			result_value[lane] <= lane_result;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			result_valid <= 1'b0;
			result_thread_idx <= '0;
			result_mask <= '0;
		end
		else
		begin
			result_valid <= fx2.valid;
			result_thread_idx <= fx2.thread_idx;
			result_mask <= fx2.mask;
		end
	end

	// Every delivered result came from a decoded op
	assert property (@(posedge clk) disable iff (reset)
		result_valid |-> $past(fx2.op) inside {OP_FADD, OP_FSUB, OP_FMUL, OP_FTOI,
		OP_MUL_LO, OP_MULH_S});
endmodule

// File: fp_format_pkg.sv
// Numeric format types for the vector FP pipeline
// Lane scalar, lane mask, IEEE single field widths and constants
`include "fp_macros.svh"

package fp_format_pkg;

	// IEEE 754 single-precision layout
	localparam int EXP_WIDTH = 8;
	localparam int FRAC_WIDTH = 23;
	localparam int EXP_BIAS = 127;

	// One lane value, float or integer
	typedef logic [31:0] scalar_t;

	// One enable bit per lane
	typedef logic [`VECTOR_LANES-1:0] lane_mask_t;

	// Biased exponent field
	typedef logic [EXP_WIDTH-1:0] exponent_t;

	// All-ones exponent marks infinity or NaN
	localparam exponent_t EXP_MAX = '1;

	// Canonical quiet NaN
	localparam scalar_t QUIET_NAN = 32'h7fc00000;

	// Saturation values for float to int
	localparam scalar_t INT_MAX = 32'h7fffffff;
	localparam scalar_t INT_MIN = 32'h80000000;

endpackage

// File: fp_macros.svh
// Configuration macros for the vector FP execute pipeline
// Lane count, significand width and issue-to-result latency
`ifndef FP_MACROS_SVH
`define FP_MACROS_SVH

// 32-bit lanes per vector instruction
`define VECTOR_LANES 4

// Single-precision significand, hidden bit included
`define SIG_WIDTH 24

// Clock edges from sampled issue to result_valid
`define FP_LATENCY 3

`endif

// File: fp_pipeline.sv
// Vector FP execute pipeline top level
// Three registered stages joined by fx1_if and fx2_if
`timescale 1ns/1ps
`include "fp_macros.svh"

module fp_pipeline(
	input logic clk,
	input logic reset,

	// Issue
	input logic issue_valid,
	input fp_control_pkg::fp_op_t issue_op,
	input fp_control_pkg::thread_idx_t issue_thread_idx,
	input fp_format_pkg::lane_mask_t issue_mask,
	input fp_format_pkg::scalar_t [`VECTOR_LANES-1:0] operand_a,
	input fp_format_pkg::scalar_t [`VECTOR_LANES-1:0] operand_b,

	// Rollback from writeback
	input logic rollback_en,
	input fp_control_pkg::thread_idx_t rollback_thread_idx,
	input fp_control_pkg::pipeline_sel_t rollback_pipeline,

	// Result, three edges after the issue is sampled
	output logic result_valid,
	output fp_control_pkg::thread_idx_t result_thread_idx,
	output fp_format_pkg::lane_mask_t result_mask,
	output fp_format_pkg::scalar_t [`VECTOR_LANES-1:0] result_value);

	fx1_if fx1_bus();
	fx2_if fx2_bus();

	fp_execute_stage1 i_stage1(
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_op(issue_op),
		.issue_thread_idx(issue_thread_idx),
		.issue_mask(issue_mask),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.fx1(fx1_bus));

	fp_execute_stage2 i_stage2(
		.clk(clk),
		.reset(reset),
		.rollback_en(rollback_en),
		.rollback_thread_idx(rollback_thread_idx),
		.rollback_pipeline(rollback_pipeline),
		.fx1(fx1_bus),
		.fx2(fx2_bus));

	fp_execute_stage3 i_stage3(
		.clk(clk),
		.reset(reset),
		.fx2(fx2_bus),
		.result_valid(result_valid),
		.result_thread_idx(result_thread_idx),
		.result_mask(result_mask),
		.result_value(result_value));
endmodule

// File: fp_stage_if.sv
// Stage-to-stage interfaces of the FP execute pipeline
// fx1_if carries stage 1 to stage 2, fx2_if stage 2 to stage 3
`timescale 1ns/1ps
`include "fp_macros.svh"

interface fx1_if;
	import fp_format_pkg::*;
	import fp_control_pkg::*;

	// Control
	logic valid;
	fp_op_t op;
	thread_idx_t thread_idx;
	lane_mask_t mask;
	logic [`VECTOR_LANES-1:0] result_is_inf;
	logic [`VECTOR_LANES-1:0] result_is_nan;
	logic [`VECTOR_LANES-1:0][5:0] ftoi_shift;

	// Add path, operands ordered by magnitude
	logic [`VECTOR_LANES-1:0][`SIG_WIDTH-1:0] significand_le;
	logic [`VECTOR_LANES-1:0][`SIG_WIDTH-1:0] significand_se;
	logic [`VECTOR_LANES-1:0][4:0] se_align_shift;
	logic [`VECTOR_LANES-1:0] logical_subtract;
	exponent_t [`VECTOR_LANES-1:0] add_exponent;
	logic [`VECTOR_LANES-1:0] add_result_sign;

	// Multiply path, exponent is two's complement
	logic [`VECTOR_LANES-1:0][9:0] mul_exponent;
	logic [`VECTOR_LANES-1:0] mul_sign;
	scalar_t [`VECTOR_LANES-1:0] multiplicand;
	scalar_t [`VECTOR_LANES-1:0] multiplier;

	modport src(output valid, op, thread_idx, mask, result_is_inf, result_is_nan, ftoi_shift,
		significand_le, significand_se, se_align_shift, logical_subtract, add_exponent,
		add_result_sign, mul_exponent, mul_sign, multiplicand, multiplier);
	modport dst(input valid, op, thread_idx, mask, result_is_inf, result_is_nan, ftoi_shift,
		significand_le, significand_se, se_align_shift, logical_subtract, add_exponent,
		add_result_sign, mul_exponent, mul_sign, multiplicand, multiplier);
endinterface

interface fx2_if;
	import fp_format_pkg::*;
	import fp_control_pkg::*;

	logic valid;
	fp_op_t op;
	thread_idx_t thread_idx;
	lane_mask_t mask;
	logic [`VECTOR_LANES-1:0] result_is_inf;
	logic [`VECTOR_LANES-1:0] result_is_nan;
	logic [`VECTOR_LANES-1:0][5:0] ftoi_shift;

	// Aligned add operands plus rounding bits
	logic [`VECTOR_LANES-1:0][`SIG_WIDTH-1:0] significand_le;
	logic [`VECTOR_LANES-1:0][`SIG_WIDTH-1:0] significand_se;
	logic [`VECTOR_LANES-1:0] guard;
	logic [`VECTOR_LANES-1:0] round;
	logic [`VECTOR_LANES-1:0] sticky;
	exponent_t [`VECTOR_LANES-1:0] add_exponent;
	logic [`VECTOR_LANES-1:0] add_result_sign;
	logic [`VECTOR_LANES-1:0] logical_subtract;

	// Full product, integer or significand
	logic [`VECTOR_LANES-1:0][63:0] significand_product;
	logic [`VECTOR_LANES-1:0][9:0] mul_exponent;
	logic [`VECTOR_LANES-1:0] mul_sign;

	modport src(output valid, op, thread_idx, mask, result_is_inf, result_is_nan, ftoi_shift,
		significand_le, significand_se, guard, round, sticky, add_exponent, add_result_sign,
		logical_subtract, significand_product, mul_exponent, mul_sign);
	modport dst(input valid, op, thread_idx, mask, result_is_inf, result_is_nan, ftoi_shift,
		significand_le, significand_se, guard, round, sticky, add_exponent, add_result_sign,
		logical_subtract, significand_product, mul_exponent, mul_sign);
endinterface

// File: src.f
+incdir+.
fp_format_pkg.sv
fp_control_pkg.sv
fp_stage_if.sv
fp_execute_stage1.sv
fp_execute_stage2.sv
fp_execute_stage3.sv
fp_pipeline.sv
tb_fp_pipeline.sv

// File: tb_fp_pipeline.sv
// Testbench for the vector FP execute pipeline
// Table of float cases with rollback variants, back-to-back issue,
// LFSR sweep of the integer multiplies, closing report
`timescale 1ns/1ps
`include "fp_macros.svh"

module tb_fp_pipeline;
	import fp_format_pkg::*;
	import fp_control_pkg::*;

	typedef scalar_t [`VECTOR_LANES-1:0] lanes_t;

	// One issued instruction with its expected lanes
	typedef struct packed
	{
		fp_op_t op;
		thread_idx_t thread_idx;
		lane_mask_t mask;
		logic rollback;
		thread_idx_t rollback_thread;
		pipeline_sel_t rollback_pipe;
		lanes_t a;
		lanes_t b;
		lanes_t expected;
	} vector_row_t;

	logic clk;
	logic reset;
	logic issue_valid;
	fp_op_t issue_op;
	thread_idx_t issue_thread_idx;
	lane_mask_t issue_mask;
	lanes_t operand_a;
	lanes_t operand_b;
	logic rollback_en;
	thread_idx_t rollback_thread_idx;
	pipeline_sel_t rollback_pipeline;
	logic result_valid;
	thread_idx_t result_thread_idx;
	lane_mask_t result_mask;
	lanes_t result_value;

	vector_row_t rows[$];
	logic [31:0] lfsr_state;
	int check_count;
	int error_count;
	int timeout_count;

	fp_pipeline i_fp_pipeline(
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_op(issue_op),
		.issue_thread_idx(issue_thread_idx),
		.issue_mask(issue_mask),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.rollback_en(rollback_en),
		.rollback_thread_idx(rollback_thread_idx),
		.rollback_pipeline(rollback_pipeline),
		.result_valid(result_valid),
		.result_thread_idx(result_thread_idx),
		.result_mask(result_mask),
		.result_value(result_value));

	// 4 ns clock
	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	function automatic vector_row_t make_row(input fp_op_t op, input thread_idx_t thread_idx,
		input lane_mask_t mask, input logic rollback, input thread_idx_t rollback_thread,
		input pipeline_sel_t rollback_pipe, input lanes_t a, input lanes_t b,
		input lanes_t expected);
		vector_row_t row;
		row.op = op;
		row.thread_idx = thread_idx;
		row.mask = mask;
		row.rollback = rollback;
		row.rollback_thread = rollback_thread;
		row.rollback_pipe = rollback_pipe;
		row.a = a;
		row.b = b;
		row.expected = expected;
		return row;
	endfunction

	// Lanes listed 3 down to 0, expected values are IEEE single constants
	task automatic fill_table();
		lanes_t add_a;
		lanes_t add_b;
		lanes_t add_sum;
		// Tie to even, carry into new exponent, exact cancellation, plain sum
		add_a = {32'h3f800000, 32'h3fc00000, 32'h3fc00000, 32'h3f800000};
		add_b = {32'h33800000, 32'h3fe00000, 32'hbfc00000, 32'h40000000};
		add_sum = {32'h3f800000, 32'h40500000, 32'h00000000, 32'h40400000};
		rows.push_back(make_row(OP_FADD, 2'd0, 4'hf, 1'b0, 2'd0, PIPE_MEM,
			add_a, add_b, add_sum));
		// -1 minus -1, odd tie rounds up, sign flip, exponent drop
		rows.push_back(make_row(OP_FSUB, 2'd1, 4'hf, 1'b0, 2'd0, PIPE_MEM,
			{32'hbf800000, 32'h3f800001, 32'h3f800000, 32'h40a00000},
			{32'hbf800000, 32'hb3800000, 32'h40400000, 32'h40400000},
			{32'h00000000, 32'h3f800002, 32'hc0000000, 32'h40000000}));
		// 0 x inf, underflow to -0, overflow to -inf, rounded tie
		rows.push_back(make_row(OP_FMUL, 2'd2, 4'hf, 1'b0, 2'd0, PIPE_MEM,
			{32'h00000000, 32'h0d800000, 32'hff000000, 32'h40400000},
			{32'h7f800000, 32'h8d800000, 32'h40800000, 32'h3f800001},
			{32'h7fc00000, 32'h80000000, 32'hff800000, 32'h40400002}));
		// NaN input, inf times negative, sign, exact product
		rows.push_back(make_row(OP_FMUL, 2'd3, 4'hf, 1'b0, 2'd0, PIPE_MEM,
			{32'h7fc00001, 32'h7f800000, 32'hc0000000, 32'h3fc00000},
			{32'h3f800000, 32'hc0000000, 32'h40400000, 32'h40200000},
			{32'h7fc00000, 32'hff800000, 32'hc0c00000, 32'h40700000}));
		// 2^32 saturates, -0.75 and -2.5 and 3.75 truncate
		rows.push_back(make_row(OP_FTOI, 2'd0, 4'hf, 1'b0, 2'd0, PIPE_MEM,
			{32'h4f800000, 32'hbf400000, 32'hc0200000, 32'h40700000}, '0,
			{32'h7fffffff, 32'h00000000, 32'hfffffffe, 32'h00000003}));
		// -2^40 saturates low, lane 2 masked off, 2^30, -123.456
		rows.push_back(make_row(OP_FTOI, 2'd2, 4'b1011, 1'b0, 2'd0, PIPE_MEM,
			{32'hd3800000, 32'h3f800000, 32'h4e800000, 32'hc2f6e979}, '0,
			{32'h80000000, 32'h00000001, 32'h40000000, 32'hffffff85}));
		// Rollback variants, only the first one cancels
		rows.push_back(make_row(OP_FADD, 2'd1, 4'hf, 1'b1, 2'd1, PIPE_MEM,
			add_a, add_b, add_sum));
		rows.push_back(make_row(OP_FADD, 2'd1, 4'hf, 1'b1, 2'd2, PIPE_MEM,
			add_a, add_b, add_sum));
		rows.push_back(make_row(OP_FADD, 2'd1, 4'hf, 1'b1, 2'd1, PIPE_INT,
			add_a, add_b, add_sum));
		rows.push_back(make_row(OP_FADD, 2'd3, 4'b0110, 1'b1, 2'd3, PIPE_FP,
			add_a, add_b, add_sum));
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic draw_word(output scalar_t word);
		word = '0;
		for (int i = 0; i < 32; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			word = {word[30:0], lfsr_state[0]};
		end
	endtask

	// Low word of the unsigned product or high word of the signed one
	function automatic scalar_t int_mul_expected(input fp_op_t op, input scalar_t a,
		input scalar_t b);
		longint signed_a;
		longint signed_b;
		longint signed_product;
		logic [63:0] unsigned_product;
		signed_a = longint'($signed(a));
		signed_b = longint'($signed(b));
		signed_product = signed_a * signed_b;
		unsigned_product = {32'd0, a} * {32'd0, b};
		if (op == OP_MULH_S)
			return signed_product[63:32];
		return unsigned_product[31:0];
	endfunction

	// Memory-pipe rollback of the same thread cancels
	function automatic logic predicts_squash(input vector_row_t row);
		return row.rollback && row.rollback_thread == row.thread_idx
			&& row.rollback_pipe == PIPE_MEM;
	endfunction

	task automatic drive_issue(input vector_row_t row);
		issue_valid <= 1'b1;
		issue_op <= row.op;
		issue_thread_idx <= row.thread_idx;
		issue_mask <= row.mask;
		operand_a <= row.a;
		operand_b <= row.b;
	endtask

	// Sampled on the falling edge, away from the register updates
	task automatic wait_result(input int limit, output logic seen);
		seen = 1'b0;
		for (int cycle = 0; cycle < limit && !seen; cycle++)
		begin
			@(negedge clk);
			seen = result_valid;
		end
	endtask

	task automatic check_result(input vector_row_t row, input int index);
		check_count++;
		if (result_thread_idx !== row.thread_idx || result_mask !== row.mask)
		begin
			$display("FAILED at %0t: row %0d thread %0d mask %b, expected thread %0d mask %b",
				$time, index, result_thread_idx, result_mask, row.thread_idx, row.mask);
			error_count++;
		end
		// Masked-off lanes carry no defined value
		for (int lane = 0; lane < `VECTOR_LANES; lane++)
		begin
			if (row.mask[lane])
			begin
				check_count++;
				if (result_value[lane] !== row.expected[lane])
				begin
					$display("FAILED at %0t: row %0d lane %0d got %h, expected %h", $time,
						index, lane, result_value[lane], row.expected[lane]);
					error_count++;
				end
			end
		end
	endtask

	task automatic run_row(input vector_row_t row, input int index);
		logic seen;
		@(posedge clk);
		drive_issue(row);
		// Rollback lands while the instruction sits in fx1
		@(posedge clk);
		issue_valid <= 1'b0;
		rollback_en <= row.rollback;
		rollback_thread_idx <= row.rollback_thread;
		rollback_pipeline <= row.rollback_pipe;
		@(posedge clk);
		rollback_en <= 1'b0;
		if (predicts_squash(row))
		begin
			wait_result(`FP_LATENCY + 2, seen);
			check_count++;
			if (seen)
			begin
				$display("FAILED at %0t: row %0d gave a result after a matching rollback",
					$time, index);
				error_count++;
			end
		end
		else
		begin
			wait_result(10, seen);
			if (!seen)
			begin
				$display("Timeout: row %0d gave no result within 10 cycles", index);
				timeout_count++;
			end
			else
				check_result(row, index);
		end
	endtask

	initial
	begin
		vector_row_t row;
		scalar_t word_a;
		scalar_t word_b;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_op = OP_FADD;
		issue_thread_idx = '0;
		issue_mask = '0;
		operand_a = '0;
		operand_b = '0;
		rollback_en = 1'b0;
		rollback_thread_idx = '0;
		rollback_pipeline = PIPE_MEM;
		lfsr_state = 32'ha6f7f395;
		check_count = 0;
		error_count = 0;
		timeout_count = 0;
		fill_table();
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		foreach (rows[i])
			run_row(rows[i], i);

		// Three issues on consecutive edges, results in the same order
		for (int k = 0; k < `FP_LATENCY + 4; k++)
		begin
			@(posedge clk);
			if (k < 3)
				drive_issue(rows[k]);
			else
				issue_valid <= 1'b0;
			@(negedge clk);
			if (k >= `FP_LATENCY && k < `FP_LATENCY + 3)
			begin
				if (result_valid)
					check_result(rows[k - `FP_LATENCY], k - `FP_LATENCY);
				else
				begin
					$display("FAILED at %0t: back-to-back result %0d missing", $time,
						k - `FP_LATENCY);
					error_count++;
				end
			end
			else if (result_valid)
			begin
				$display("FAILED at %0t: result_valid high in back-to-back cycle %0d",
					$time, k);
				error_count++;
			end
		end

		// Integer multiply sweep, alternating low and signed high word
		for (int n = 0; n < 16; n++)
		begin
			row.op = n[0] ? OP_MULH_S : OP_MUL_LO;
			row.thread_idx = thread_idx_t'(n);
			row.mask = '1;
			row.rollback = 1'b0;
			row.rollback_thread = '0;
			row.rollback_pipe = PIPE_MEM;
			for (int lane = 0; lane < `VECTOR_LANES; lane++)
			begin
				draw_word(word_a);
				draw_word(word_b);
				row.a[lane] = word_a;
				row.b[lane] = word_b;
				row.expected[lane] = int_mul_expected(row.op, word_a, word_b);
			end
			run_row(row, rows.size() + n);
		end

		$display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
			timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end
endmodule
